/* tb/vfifo_testdata.txt */
# Virtual FIFO commands, one per line, data base and mask in hex, counts and flags in decimal
# test NAME | configure BASE MASK | enable | write DATA | pop DATA | burst N FIRST | drain N FIRST
# status OCC EMPTY FULL ACTIVE | levels IN_READY OUT_VALID | idle N | reset
test after_reset
levels 0 0
status 0 1 0 0
test order_mask7
configure 20 7
enable
write a0000001
write a0000002
write a0000003
write a0000004
write a0000005
pop a0000001
pop a0000002
pop a0000003
pop a0000004
pop a0000005
levels 1 0
test fill_mask7
burst 8 b0000000
levels 0 1
write deadbeef
status 8 0 1 1
drain 8 b0000000
levels 1 0
test cfg_frozen
configure 40 3
burst 8 c0000000
levels 0 1
write 0badc0de
drain 8 c0000000
test partial
write d0000001
write d0000002
write d0000003
pop d0000001
status 2 0 0 1
test reset_wrap16
reset
levels 0 0
status 0 1 0 0
configure 80 f
enable
burst 16 e0000000
status 16 0 1 1
drain 10 e0000000
burst 10 e0000010
drain 16 e000000a
idle 3
burst 14 e000001a
drain 14 e000001a
status 0 1 0 0

/* sim.f */
design/vfifo_pkg.sv
design/vfifo_cfg.sv
design/vfifo_ring.sv
design/vfifo_status.sv
design/vfifo_top.sv
tb/vfifo_clkgen.sv
tb/vfifo_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := vfifo_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'ALL CHECKS PASSED'

clean:
	rm -rf $(OBJ_DIR)

/* tb/vfifo_tb.sv */
// Virtual FIFO testbench
// Runs the command list of the test data file against a queue model of the ring

`default_nettype none

module vfifo_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string DATA_FILE     = "tb/vfifo_testdata.txt";
    localparam int    RESET_CYCLES  = 4;
    // Snapshot period plus the two flag stages and some margin
    localparam int    SETTLE_CYCLES = 2**vfifo_pkg::STS_PERIOD_LOG2 + 4;

    logic             ch_clk;
    logic             cfg_reset;
    logic             reset_req;
    logic             cfg_enable;
    vfifo_pkg::addr_t cfg_base_addr;
    vfifo_pkg::addr_t cfg_size_mask;
    vfifo_pkg::data_t in_data;
    logic             in_valid;
    logic             out_pop;
    logic             in_ready;
    vfifo_pkg::data_t out_data;
    logic             out_valid;
    vfifo_pkg::occ_t  sts_occupancy;
    logic             sts_empty;
    logic             sts_full;
    logic             sts_reset;
    logic             sts_active;

    // Model of the ring contents and of the latched configuration
    vfifo_pkg::data_t model_q[$];
    logic             model_enabled;
    vfifo_pkg::addr_t model_mask;

    string test_name;
    int    check_count;
    int    error_count;
    int    watchdog_cycles;

    vfifo_clkgen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) vfifo_clkgen_i (
        .reset_req (reset_req),
        .ch_clk    (ch_clk),
        .cfg_reset (cfg_reset)
    );

    vfifo_top #(
        .MEM_DEPTH_LOG2 (vfifo_pkg::ADDR_W)
    ) vfifo_top_i (
        .ch_clk        (ch_clk),
        .cfg_reset     (cfg_reset),
        .cfg_enable    (cfg_enable),
        .cfg_base_addr (cfg_base_addr),
        .cfg_size_mask (cfg_size_mask),
        .in_data       (in_data),
        .in_valid      (in_valid),
        .out_pop       (out_pop),
        .in_ready      (in_ready),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .sts_occupancy (sts_occupancy),
        .sts_empty     (sts_empty),
        .sts_full      (sts_full),
        .sts_reset     (sts_reset),
        .sts_active    (sts_active)
    );

    task automatic step();
        @(posedge ch_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic verify_field_count(input int got, input int wanted, input string cmd);
        assert (got == wanted) else begin
            error_count++;
            $display("ERROR %s: the %s line in the test data has missing fields",
                     test_name, cmd);
        end
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $urandom_range(3, 0);
        repeat (gap) step();
    endtask

    task automatic skip_rest_of_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic configure_ring(input logic [31:0] base, input logic [31:0] mask);
        cfg_base_addr = vfifo_pkg::addr_t'(base);
        cfg_size_mask = vfifo_pkg::addr_t'(mask);
        step();
    endtask

    // The shadow registers still follow the inputs at the enabling edge
    task automatic enable_ring();
        cfg_enable = 1'b1;
        step();
        cfg_enable = 1'b0;
        if (!model_enabled) begin
            model_enabled = 1'b1;
            model_mask    = cfg_size_mask;
        end
    endtask

    task automatic write_word(input vfifo_pkg::data_t value);
        logic exp_ready;
        exp_ready = model_enabled && (model_q.size() < int'(model_mask) + 1);
        check_value("in_ready", 32'(exp_ready), 32'(in_ready));
        in_data  = value;
        in_valid = 1'b1;
        step();
        in_valid = 1'b0;
        if (exp_ready) begin
            model_q.push_back(value);
        end
        idle_gap();
    endtask

    task automatic pop_word(input vfifo_pkg::data_t expected);
        logic exp_valid;
        exp_valid = model_enabled && (model_q.size() != 0);
        if (model_q.size() == 0) begin
            error_count++;
            $display("ERROR %s: pop requested but the model holds no word", test_name);
        end else begin
            check_value("test data pop value", model_q[0], expected);
        end
        check_value("out_valid", 32'(exp_valid), 32'(out_valid));
        check_value("out_data", expected, out_data);
        out_pop = 1'b1;
        step();
        out_pop = 1'b0;
        if (exp_valid) begin
            void'(model_q.pop_front());
        end
        idle_gap();
    endtask

    task automatic check_status(input logic [31:0] occ, input logic [31:0] emp,
                                input logic [31:0] full_flag, input logic [31:0] act);
        repeat (SETTLE_CYCLES) step();
        check_value("sts_occupancy", occ, 32'(sts_occupancy));
        check_value("sts_empty", emp, 32'(sts_empty));
        check_value("sts_full", full_flag, 32'(sts_full));
        check_value("sts_active", act, 32'(sts_active));
        check_value("sts_reset", 32'd0, 32'(sts_reset));
    endtask

    // Status reports the reset while it is still held
    task automatic pulse_reset();
        reset_req = 1'b1;
        repeat (RESET_CYCLES) step();
        check_value("sts_reset during reset", 32'd1, 32'(sts_reset));
        reset_req = 1'b0;
        step();
        model_q.delete();
        model_enabled = 1'b0;
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin : main
        int          fd;
        int          line_count;
        int          ch;
        int          code;
        string       cmd;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        logic [31:0] arg_d;

        reset_req       = 1'b0;
        cfg_enable      = 1'b0;
        cfg_base_addr   = '0;
        cfg_size_mask   = '0;
        in_data         = '0;
        in_valid        = 1'b0;
        out_pop         = 1'b0;
        model_enabled   = 1'b0;
        model_mask      = '0;
        test_name       = "startup";
        check_count     = 0;
        error_count     = 0;
        watchdog_cycles = 0;
        void'($urandom(32'h0f0e_4103));

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("ERROR: cannot open the test data file %s", DATA_FILE);
        end else begin
            // Count lines to size the watchdog
            line_count = 0;
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == 10) begin
                    line_count++;
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
            watchdog_cycles = 200 + 20 * line_count;
            fd = $fopen(DATA_FILE, "r");
            @(negedge cfg_reset);
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    skip_rest_of_line(fd);
                end else if (cmd == "test") begin
                    code = $fscanf(fd, "%s", test_name);
                    verify_field_count(code, 1, cmd);
                end else if (cmd == "configure") begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    verify_field_count(code, 2, cmd);
                    configure_ring(arg_a, arg_b);
                end else if (cmd == "enable") begin
                    enable_ring();
                end else if (cmd == "write") begin
                    code = $fscanf(fd, "%h", arg_a);
                    verify_field_count(code, 1, cmd);
                    write_word(arg_a);
                end else if (cmd == "pop") begin
                    code = $fscanf(fd, "%h", arg_a);
                    verify_field_count(code, 1, cmd);
                    pop_word(arg_a);
                end else if (cmd == "burst" || cmd == "drain") begin
                    code = $fscanf(fd, "%d %h", arg_a, arg_b);
                    verify_field_count(code, 2, cmd);
                    for (int i = 0; i < int'(arg_a); i++) begin
                        if (cmd == "burst") begin
                            write_word(arg_b + 32'(i));
                        end else begin
                            pop_word(arg_b + 32'(i));
                        end
                    end
                end else if (cmd == "status") begin
                    code = $fscanf(fd, "%d %d %d %d", arg_a, arg_b, arg_c, arg_d);
                    verify_field_count(code, 4, cmd);
                    check_status(arg_a, arg_b, arg_c, arg_d);
                end else if (cmd == "levels") begin
                    code = $fscanf(fd, "%d %d", arg_a, arg_b);
                    verify_field_count(code, 2, cmd);
                    check_value("in_ready", arg_a, 32'(in_ready));
                    check_value("out_valid", arg_b, 32'(out_valid));
                end else if (cmd == "idle") begin
                    code = $fscanf(fd, "%d", arg_a);
                    verify_field_count(code, 1, cmd);
                    repeat (arg_a) step();
                end else if (cmd == "reset") begin
                    pulse_reset();
                end else begin
                    error_count++;
                    $display("ERROR: unknown command %s in the test data", cmd);
                end
            end
            $fclose(fd);
        end
        finish_run();
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge ch_clk);
        error_count++;
        $display("ERROR: watchdog expired after %0d cycles in test %s", watchdog_cycles, test_name);
        finish_run();
    end

endmodule

`default_nettype wire

/* tb/vfifo_clkgen.sv */
// Testbench clock and reset generator
// Free-running clock with a power-on reset that the testbench can request again

`default_nettype none

module vfifo_clkgen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 4
) (
    input  wire  reset_req,
    output logic ch_clk,
    output logic cfg_reset
);

    timeunit 1ns;
    timeprecision 1ps;

    logic req_seen;

    initial begin
        ch_clk = 1'b0;
        forever #(HALF_PERIOD) ch_clk = ~ch_clk;
    end

    // Reset moves 1 ns after a rising edge, like every other DUT input
    initial begin
        cfg_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge ch_clk);
        #1;
        cfg_reset = 1'b0;
        forever begin
            @(posedge ch_clk);
            req_seen = reset_req;
            #1;
            cfg_reset = req_seen;
        end
    end

endmodule

`default_nettype wire

/* design/vfifo_top.sv */
// Virtual FIFO top level
// Configuration shell, single ring channel and status registers

`default_nettype none

module vfifo_top #(
    parameter int MEM_DEPTH_LOG2 = vfifo_pkg::ADDR_W
) (
    input  wire               ch_clk,
    input  wire               cfg_reset,
    input  wire               cfg_enable,
    input  vfifo_pkg::addr_t  cfg_base_addr,
    input  vfifo_pkg::addr_t  cfg_size_mask,
    input  vfifo_pkg::data_t  in_data,
    input  wire               in_valid,
    input  wire               out_pop,
    output logic              in_ready,
    output vfifo_pkg::data_t  out_data,
    output logic              out_valid,
    output vfifo_pkg::occ_t   sts_occupancy,
    output logic              sts_empty,
    output logic              sts_full,
    output logic              sts_reset,
    output logic              sts_active
);

    // Latched configuration
    logic             enable;
    vfifo_pkg::addr_t base_addr;
    vfifo_pkg::addr_t size_mask;

    // Raw channel state ahead of the status registers
    vfifo_pkg::occ_t  occupancy;
    logic             empty;
    logic             full;
    logic             active;
    logic             resetting;

    vfifo_cfg vfifo_cfg_i (
        .ch_clk        (ch_clk),
        .cfg_reset     (cfg_reset),
        .cfg_enable    (cfg_enable),
        .cfg_base_addr (cfg_base_addr),
        .cfg_size_mask (cfg_size_mask),
        .enable        (enable),
        .base_addr     (base_addr),
        .size_mask     (size_mask)
    );

    vfifo_ring #(
        .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) vfifo_ring_i (
        .ch_clk    (ch_clk),
        .cfg_reset (cfg_reset),
        .enable    (enable),
        .base_addr (base_addr),
        .size_mask (size_mask),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_pop   (out_pop),
        .occupancy (occupancy),
        .empty     (empty),
        .full      (full),
        .active    (active),
        .resetting (resetting)
    );

    vfifo_status vfifo_status_i (
        .ch_clk        (ch_clk),
        .cfg_reset     (cfg_reset),
        .occupancy     (occupancy),
        .empty         (empty),
        .full          (full),
        .active        (active),
        .resetting     (resetting),
        .sts_occupancy (sts_occupancy),
        .sts_empty     (sts_empty),
        .sts_full      (sts_full),
        .sts_reset     (sts_reset),
        .sts_active    (sts_active)
    );

endmodule

`default_nettype wire

/* design/vfifo_status.sv */
// Virtual FIFO status registers
// Flags go through two register stages, occupancy is sampled once per period

`default_nettype none

module vfifo_status (
    input  wire               ch_clk,
    input  wire               cfg_reset,
    input  vfifo_pkg::occ_t   occupancy,
    input  wire               empty,
    input  wire               full,
    input  wire               active,
    input  wire               resetting,
    output vfifo_pkg::occ_t   sts_occupancy,
    output logic              sts_empty,
    output logic              sts_full,
    output logic              sts_reset,
    output logic              sts_active
);

    // Flag order is {reset, active, full, empty}
    logic [3:0] flags_s1;
    logic [3:0] flags_s2;

    vfifo_pkg::sts_cnt_t sample_cnt;
    logic                sample_strobe;

    // Reset flag stages are preset so sts_reset reads high during reset
    always_ff @(posedge ch_clk) begin
        if (cfg_reset) begin
            flags_s1 <= 4'b1000;
            flags_s2 <= 4'b1000;
        end else begin
            flags_s1 <= {resetting, active, full, empty};
            flags_s2 <= flags_s1;
        end
    end

    assign sts_reset  = flags_s2[3];
    assign sts_active = flags_s2[2];
    assign sts_full   = flags_s2[1];
    assign sts_empty  = flags_s2[0];

    // Counter wrap marks the sampling point
    assign sample_strobe = (sample_cnt == '1);

    always_ff @(posedge ch_clk) begin
        if (cfg_reset) begin
            sample_cnt    <= '0;
            sts_occupancy <= '0;
        end else begin
            sample_cnt <= sample_cnt + vfifo_pkg::sts_cnt_t'(1);
            if (sample_strobe) begin
                sts_occupancy <= occupancy;
            end
        end
    end

    property p_empty_full_excl;
        @(posedge ch_clk) disable iff (cfg_reset)
        !(sts_empty && sts_full);
    endproperty

    a_empty_full_excl: assert property (p_empty_full_excl)
        else $error("vfifo_status: empty and full reported together");

endmodule

`default_nettype wire

/* design/vfifo_ring.sv */
// Virtual FIFO ring channel
// Stores words in an on-chip memory region at base_addr, pointers wrapped by size_mask

`default_nettype none

module vfifo_ring #(
    parameter int MEM_DEPTH_LOG2 = vfifo_pkg::ADDR_W
) (
    input  wire               ch_clk,
    input  wire               cfg_reset,
    input  wire               enable,
    input  vfifo_pkg::addr_t  base_addr,
    input  vfifo_pkg::addr_t  size_mask,
    input  vfifo_pkg::data_t  in_data,
    input  wire               in_valid,
    output logic              in_ready,
    output vfifo_pkg::data_t  out_data,
    output logic              out_valid,
    input  wire               out_pop,
    output vfifo_pkg::occ_t   occupancy,
    output logic              empty,
    output logic              full,
    output logic              active,
    output logic              resetting
);

    // Storage region shared by every ring placement
    vfifo_pkg::data_t mem [2**MEM_DEPTH_LOG2];

    vfifo_pkg::addr_t wr_ptr;
    vfifo_pkg::addr_t rd_ptr;
    vfifo_pkg::addr_t wr_addr;
    vfifo_pkg::addr_t rd_addr;
    vfifo_pkg::occ_t  capacity;

    logic [MEM_DEPTH_LOG2-1:0] wr_idx;
    logic [MEM_DEPTH_LOG2-1:0] rd_idx;

    logic wr_en;
    logic rd_en;

    // Ring holds size_mask+1 words
    assign capacity = {1'b0, size_mask} + vfifo_pkg::occ_t'(1);

    assign empty     = (occupancy == '0);
    assign full      = (occupancy == capacity);
    assign active    = enable && !empty;
    assign resetting = cfg_reset;

    assign in_ready  = enable && !full;
    assign out_valid = enable && !empty;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_pop && out_valid;

    // Pointer offset inside the ring, relocated to the base address
    assign wr_addr = base_addr + (wr_ptr & size_mask);
    assign rd_addr = base_addr + (rd_ptr & size_mask);

    assign wr_idx = wr_addr[MEM_DEPTH_LOG2-1:0];
    assign rd_idx = rd_addr[MEM_DEPTH_LOG2-1:0];

    always_ff @(posedge ch_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= in_data;
        end
    end

    // Oldest word is visible without a read cycle
    assign out_data = mem[rd_idx];

    always_ff @(posedge ch_clk) begin
        if (cfg_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + vfifo_pkg::addr_t'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + vfifo_pkg::addr_t'(1);
            end
            // Write and pop in the same cycle cancel out
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + vfifo_pkg::occ_t'(1);
                2'b01:   occupancy <= occupancy - vfifo_pkg::occ_t'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

    property p_occ_bound;
        @(posedge ch_clk) disable iff (cfg_reset)
        occupancy <= capacity;
    endproperty

    a_occ_bound: assert property (p_occ_bound)
        else $error("vfifo_ring: occupancy above ring capacity");

    // A full ring can only drain, a write in the same cycle must be refused
    property p_no_write_full;
        @(posedge ch_clk) disable iff (cfg_reset)
        full |=> (occupancy <= $past(occupancy));
    endproperty

    a_no_write_full: assert property (p_no_write_full)
        else $error("vfifo_ring: word accepted while full");

endmodule

`default_nettype wire

/* design/vfifo_cfg.sv */
// Virtual FIFO configuration block
// Holds the enable latch and shadows the ring base address and size mask

`default_nettype none

module vfifo_cfg (
    input  wire               ch_clk,
    input  wire               cfg_reset,
    input  wire               cfg_enable,
    input  vfifo_pkg::addr_t  cfg_base_addr,
    input  vfifo_pkg::addr_t  cfg_size_mask,
    output logic              enable,
    output vfifo_pkg::addr_t  base_addr,
    output vfifo_pkg::addr_t  size_mask
);

    // Enable is sticky, only a configuration reset takes it down
    always_ff @(posedge ch_clk) begin
        if (cfg_reset) begin
            enable <= 1'b0;
        end else if (cfg_enable) begin
            enable <= 1'b1;
        end
    end

    // Shadow registers track the inputs only while the FIFO is disabled
    always_ff @(posedge ch_clk) begin
        if (!enable) begin
            base_addr <= cfg_base_addr;
            size_mask <= cfg_size_mask;
        end
    end

    // Ring geometry must stay frozen for as long as the FIFO runs
    property p_cfg_frozen;
        @(posedge ch_clk) disable iff (cfg_reset)
        enable |=> ($stable(base_addr) && $stable(size_mask));
    endproperty

    a_cfg_frozen: assert property (p_cfg_frozen)
        else $error("vfifo_cfg: base address or size mask changed while enabled");

endmodule

`default_nettype wire

/* design/vfifo_pkg.sv */
// Virtual FIFO shared definitions
// Word, address and occupancy widths used by the RTL and the testbench

`default_nettype none

package vfifo_pkg;

    // Width of one stored FIFO word
    parameter int DATA_W = 32;

    // Memory word address width, 256 words of storage
    parameter int ADDR_W = 8;

    // Occupancy needs one extra bit to hold a completely full memory
    parameter int OCC_W = ADDR_W + 1;

    // Status occupancy snapshot period is 2**STS_PERIOD_LOG2 cycles
    parameter int STS_PERIOD_LOG2 = 3;

    // One FIFO word
    typedef logic [DATA_W-1:0] data_t;

    // Base address, size mask and pointer values
    typedef logic [ADDR_W-1:0] addr_t;

    // Occupancy from 0 up to the full memory size
    typedef logic [OCC_W-1:0] occ_t;

    // Free-running counter that paces the occupancy snapshot
    typedef logic [STS_PERIOD_LOG2-1:0] sts_cnt_t;

endpackage

`default_nettype wire
